// ==== source/simd_pkg.sv ====
// simd slice definitions
package simd_pkg;

	// ==================================================
	// vector sizes
	// ==================================================
	// lanes per vector
	localparam int VSIZE = 4;
	localparam int DATA_BW = 16;
	// half lane for the split multiplier
	localparam int HALF_BW = DATA_BW / 2;
	// shift amount width for arithmetic shift
	localparam int SHAMT_BW = $clog2(DATA_BW);
	// flattened vector with lane 0 in the low bits
	localparam int FLAT_BW = VSIZE * DATA_BW;
	// register file
	localparam int NREG = 16;
	localparam int REG_ABW = $clog2(NREG);
	// temporary buffer with index 0 as the newest entry
	localparam int TBUF_SIZE = 4;
	localparam int TBUF_ABW = $clog2(TBUF_SIZE);

	// ==================================================
	// instruction layout
	// ==================================================
	localparam int ISA_BW = 23;
	// opcode sits on top and immediate at the bottom
	localparam int OPC_POS = 20;
	localparam int OPC_BW = 3;
	localparam int DST_POS = 18;
	localparam int DST_BW = 2;
	localparam int WADDR_POS = 14;
	localparam int WADDR_BW = 4;
	localparam int RADDR_POS = 10;
	localparam int RADDR_BW = 4;
	localparam int SRCB_POS = 8;
	localparam int SRCB_BW = 2;
	localparam int IMM_POS = 0;
	localparam int IMM_BW = 8;

	// ==================================================
	// encodings
	// ==================================================
	typedef enum logic [OPC_BW-1:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_MUL  = 3'd2,
		OP_SHR  = 3'd3,
		OP_MAX  = 3'd4,
		OP_MOVB = 3'd5
	} op_e;

	typedef enum logic [DST_BW-1:0] {
		DST_REG  = 2'd0,
		DST_TMP  = 2'd1,
		DST_DRAM = 2'd2
	} dst_e;

	typedef enum logic [SRCB_BW-1:0] {
		SRC_TMP  = 2'd0,
		SRC_IMM  = 2'd1,
		SRC_SRAM = 2'd2
	} srcb_e;

	// alu latency in cycles after launch
	localparam int LAT_MUL = 3;
	localparam int LAT_BASIC = 1;
	localparam int LAT_BW = $clog2(LAT_MUL + 1);

	typedef enum logic [1:0] {
		S_IDLE   = 2'd0,
		S_OPND   = 2'd1,
		S_EXEC   = 2'd2,
		S_RETIRE = 2'd3
	} state_e;

endpackage

// ==== source/simd_sequencer.sv ====
// simd instruction sequencer
module simd_sequencer
	import simd_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,
	// instruction port
	input  logic               i_inst_rdy,
	input  logic [ISA_BW-1:0]  i_inst,
	output logic               o_inst_ack,
	// sram operand port
	input  logic               i_sramrd_rdy,
	output logic               o_sramrd_ack,
	// dram result port
	output logic               o_dramwd_rdy,
	input  logic               i_dramwd_ack,
	output logic               o_commit_dval,
	// register file control
	output logic               o_reg_re,
	output logic [REG_ABW-1:0] o_reg_raddr,
	output logic               o_reg_we,
	output logic [REG_ABW-1:0] o_reg_waddr,
	output logic               o_tbuf_push,
	// latency timer
	output logic               o_timer_start,
	output logic               o_timer_mul,
	input  logic               i_lat_done,
	// alu control
	output logic               o_alu_launch,
	output op_e                o_opcode,
	output srcb_e              o_srcb,
	output logic [IMM_BW-1:0]  o_imm
);

	// ==================================================
	// state and latched instruction
	// ==================================================
	state_e state_r;
	state_e state_nxt;
	op_e opcode_r;
	dst_e dst_r;
	srcb_e srcb_r;
	logic [WADDR_BW-1:0] waddr_r;
	logic [IMM_BW-1:0] imm_r;
	// handshake qualifiers
	logic accept;
	logic opnd_ok;
	logic commit;

	// accept only while idle with ack following rdy combinationally
	assign accept = (state_r == S_IDLE) && i_inst_rdy;
	assign o_inst_ack = accept;
	// register read goes out in the accept cycle with data valid in S_OPND
	assign o_reg_re = accept;
	assign o_reg_raddr = i_inst[RADDR_POS +: RADDR_BW];

	// b operand is ready unless we still wait on sram
	assign opnd_ok = (srcb_r != SRC_SRAM) || i_sramrd_rdy;
	assign o_sramrd_ack = (state_r == S_OPND) && (srcb_r == SRC_SRAM) && i_sramrd_rdy;
	assign o_alu_launch = (state_r == S_OPND) && opnd_ok;
	// timer starts with the alu so both see the same latency
	assign o_timer_start = o_alu_launch;
	assign o_timer_mul = (opcode_r == OP_MUL);

	// ==================================================
	// destination decode
	// ==================================================
	// dram holds the retire until ack while other targets retire at once
	assign o_dramwd_rdy = (state_r == S_RETIRE) && (dst_r == DST_DRAM);
	assign commit = (state_r == S_RETIRE) && ((dst_r != DST_DRAM) || i_dramwd_ack);
	assign o_commit_dval = commit;
	assign o_reg_we = (state_r == S_RETIRE) && (dst_r == DST_REG);
	assign o_tbuf_push = (state_r == S_RETIRE) && (dst_r == DST_TMP);
	assign o_reg_waddr = waddr_r;

	// fields seen by the alu
	assign o_opcode = opcode_r;
	assign o_srcb = srcb_r;
	assign o_imm = imm_r;

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		state_nxt = state_r;
		case (state_r)
			S_IDLE:   if (accept) state_nxt = S_OPND;
			S_OPND:   if (opnd_ok) state_nxt = S_EXEC;
			S_EXEC:   if (i_lat_done) state_nxt = S_RETIRE;
			S_RETIRE: if (commit) state_nxt = S_IDLE;
			default:  state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= S_IDLE;
		end else begin
			state_r <= state_nxt;
		end
	end

	// instruction fields stay stable until the next accept
	always_ff @(posedge i_clk) begin
		if (accept) begin
			opcode_r <= op_e'(i_inst[OPC_POS +: OPC_BW]);
			dst_r <= dst_e'(i_inst[DST_POS +: DST_BW]);
			waddr_r <= i_inst[WADDR_POS +: WADDR_BW];
			srcb_r <= srcb_e'(i_inst[SRCB_POS +: SRCB_BW]);
			imm_r <= i_inst[IMM_POS +: IMM_BW];
		end
	end

endmodule

// ==== source/simd_op_timer.sv ====
// alu latency timer
module simd_op_timer
	import simd_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	// selects the multiplier latency
	input  logic i_mul,
	output logic o_done
);

	// ==================================================
	// down counter
	// ==================================================
	// zero means idle
	logic [LAT_BW-1:0] cnt_r;
	logic [LAT_BW-1:0] load_val;

	assign load_val = i_mul ? LAT_BW'(LAT_MUL) : LAT_BW'(LAT_BASIC);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cnt_r <= '0;
		end else if (i_start) begin
			cnt_r <= load_val;
		end else if (cnt_r != '0) begin
			cnt_r <= cnt_r - LAT_BW'(1);
		end
	end

	// done in the last counted cycle and the count steps to zero after it
	// one cycle after start for basic ops and three for mul
	assign o_done = (cnt_r == LAT_BW'(1));

endmodule

// ==== source/simd_alu.sv ====
// four lane simd alu
module simd_alu
	import simd_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_launch,
	input  op_e                i_opcode,
	input  srcb_e              i_srcb,
	input  logic [IMM_BW-1:0]  i_imm,
	// operand a from the register file
	input  logic [FLAT_BW-1:0] i_a,
	input  logic [FLAT_BW-1:0] i_sram,
	input  logic [FLAT_BW-1:0] i_tbuf [TBUF_SIZE],
	output logic [FLAT_BW-1:0] o_result
);

	// ==================================================
	// operand b select
	// ==================================================
	logic [DATA_BW-1:0] imm_ext;
	logic [FLAT_BW-1:0] b_vec;

	assign imm_ext = {{(DATA_BW-IMM_BW){i_imm[IMM_BW-1]}}, i_imm};

	always_comb begin
		case (i_srcb)
			// low imm bits pick the tmp entry with 0 newest
			SRC_TMP:  b_vec = i_tbuf[i_imm[TBUF_ABW-1:0]];
			SRC_IMM:  b_vec = {VSIZE{imm_ext}};
			SRC_SRAM: b_vec = i_sram;
			default:  b_vec = '0;
		endcase
	end

	// ==================================================
	// lane datapath
	// ==================================================
	logic [FLAT_BW-1:0] basic_nxt;
	logic [DATA_BW-1:0] plo_nxt [VSIZE];
	logic [HALF_BW-1:0] phi_nxt [VSIZE];

	always_comb begin
		logic [DATA_BW-1:0] a_l;
		logic [DATA_BW-1:0] b_l;
		logic [DATA_BW+HALF_BW-1:0] plo_full;
		logic [DATA_BW-1:0] phi_full;
		for (int i = 0; i < VSIZE; i++) begin
			a_l = i_a[i*DATA_BW +: DATA_BW];
			b_l = b_vec[i*DATA_BW +: DATA_BW];
			case (i_opcode)
				OP_ADD:  basic_nxt[i*DATA_BW +: DATA_BW] = a_l + b_l;
				OP_SUB:  basic_nxt[i*DATA_BW +: DATA_BW] = a_l - b_l;
				OP_SHR:  basic_nxt[i*DATA_BW +: DATA_BW] = $signed(a_l) >>> i_imm[SHAMT_BW-1:0];
				OP_MAX:  basic_nxt[i*DATA_BW +: DATA_BW] =
					($signed(a_l) > $signed(b_l)) ? a_l : b_l;
				OP_MOVB: basic_nxt[i*DATA_BW +: DATA_BW] = b_l;
				default: basic_nxt[i*DATA_BW +: DATA_BW] = '0;
			endcase
			// low 16 bits of a*b from two partial products
			// a_hi*b_lo only reaches the top half of the lane
			plo_full = a_l[HALF_BW-1:0] * b_l;
			phi_full = a_l[DATA_BW-1:HALF_BW] * b_l[HALF_BW-1:0];
			plo_nxt[i] = plo_full[DATA_BW-1:0];
			phi_nxt[i] = phi_full[HALF_BW-1:0];
		end
	end

	// ==================================================
	// result registers
	// ==================================================
	logic mul_sel_r;
	logic [FLAT_BW-1:0] basic_r;
	logic [DATA_BW-1:0] plo_s1 [VSIZE];
	logic [HALF_BW-1:0] phi_s1 [VSIZE];
	logic [FLAT_BW-1:0] mul_s2;
	logic [FLAT_BW-1:0] mul_s3;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			mul_sel_r <= 1'b0;
		end else if (i_launch) begin
			mul_sel_r <= (i_opcode == OP_MUL);
		end
	end

	// launch stage held until the next launch
	always_ff @(posedge i_clk) begin
		if (i_launch) begin
			basic_r <= basic_nxt;
			plo_s1 <= plo_nxt;
			phi_s1 <= phi_nxt;
		end
	end

	// mul stages 2 and 3 run freely and settle on the held stage 1
	always_ff @(posedge i_clk) begin
		for (int i = 0; i < VSIZE; i++) begin
			mul_s2[i*DATA_BW +: DATA_BW] <= plo_s1[i] + {phi_s1[i], {HALF_BW{1'b0}}};
		end
		mul_s3 <= mul_s2;
	end

	assign o_result = mul_sel_r ? mul_s3 : basic_r;

endmodule

// ==== source/simd_regfile.sv ====
// vector register file
module simd_regfile
	import simd_pkg::*;
(
	input  logic               i_clk,
	// write port used at retire
	input  logic               i_we,
	input  logic [REG_ABW-1:0] i_waddr,
	input  logic [FLAT_BW-1:0] i_wdata,
	// read port used at accept
	input  logic               i_re,
	input  logic [REG_ABW-1:0] i_raddr,
	output logic [FLAT_BW-1:0] o_rdata
);

	// ==================================================
	// storage
	// ==================================================
	// one flattened vector per entry
	logic [FLAT_BW-1:0] mem [NREG];

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// registered read that holds its value between reads
	// so operand a stays put while the slice stalls
	always_ff @(posedge i_clk) begin
		if (i_re) begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

// ==== source/simd_tmp_buffer.sv ====
// temporary vector buffer
module simd_tmp_buffer
	import simd_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_push,
	input  logic [FLAT_BW-1:0] i_wdata,
	// index 0 newest and TBUF_SIZE-1 oldest
	output logic [FLAT_BW-1:0] o_rdatas [TBUF_SIZE]
);

	// ==================================================
	// shift register
	// ==================================================
	logic [FLAT_BW-1:0] ents_r [TBUF_SIZE];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < TBUF_SIZE; i++) begin
				ents_r[i] <= '0;
			end
		end else if (i_push) begin
			// everything ages by one and the oldest falls off
			for (int i = TBUF_SIZE-1; i > 0; i--) begin
				ents_r[i] <= ents_r[i-1];
			end
			ents_r[0] <= i_wdata;
		end
	end

	// all entries visible to the alu at once
	assign o_rdatas = ents_r;

endmodule

// ==== source/simd_core.sv ====
// simd execution slice top
module simd_core
	import simd_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,
	// instruction stream
	input  logic               i_inst_rdy,
	input  logic [ISA_BW-1:0]  i_inst,
	output logic               o_inst_ack,
	// sram read
	input  logic               i_sramrd_rdy,
	input  logic [FLAT_BW-1:0] i_sramrd,
	output logic               o_sramrd_ack,
	// dram write
	output logic               o_dramwd_rdy,
	output logic [FLAT_BW-1:0] o_dramwd,
	input  logic               i_dramwd_ack,
	output logic               o_commit_dval
);

	// ==================================================
	// internal wires
	// ==================================================
	// sequencer <-> timer
	logic timer_start;
	logic timer_mul;
	logic lat_done;
	// sequencer -> register file and tmp buffer
	logic reg_re;
	logic [REG_ABW-1:0] reg_raddr;
	logic reg_we;
	logic [REG_ABW-1:0] reg_waddr;
	logic tbuf_push;
	// sequencer -> alu
	logic alu_launch;
	op_e alu_opcode;
	srcb_e alu_srcb;
	logic [IMM_BW-1:0] alu_imm;
	// operands into the alu
	logic [FLAT_BW-1:0] reg_rdata;
	logic [FLAT_BW-1:0] tbuf_rdatas [TBUF_SIZE];

	// ==================================================
	// submodules
	// ==================================================
	simd_sequencer u_seq (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_inst_rdy(i_inst_rdy),
		.i_inst(i_inst),
		.o_inst_ack(o_inst_ack),
		.i_sramrd_rdy(i_sramrd_rdy),
		.o_sramrd_ack(o_sramrd_ack),
		.o_dramwd_rdy(o_dramwd_rdy),
		.i_dramwd_ack(i_dramwd_ack),
		.o_commit_dval(o_commit_dval),
		.o_reg_re(reg_re),
		.o_reg_raddr(reg_raddr),
		.o_reg_we(reg_we),
		.o_reg_waddr(reg_waddr),
		.o_tbuf_push(tbuf_push),
		.o_timer_start(timer_start),
		.o_timer_mul(timer_mul),
		.i_lat_done(lat_done),
		.o_alu_launch(alu_launch),
		.o_opcode(alu_opcode),
		.o_srcb(alu_srcb),
		.o_imm(alu_imm)
	);

	simd_op_timer u_timer (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(timer_start),
		.i_mul(timer_mul),
		.o_done(lat_done)
	);

	// alu result is the one write bus for dram, registers and tmp buffer
	simd_alu u_alu (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_launch(alu_launch),
		.i_opcode(alu_opcode),
		.i_srcb(alu_srcb),
		.i_imm(alu_imm),
		.i_a(reg_rdata),
		.i_sram(i_sramrd),
		.i_tbuf(tbuf_rdatas),
		.o_result(o_dramwd)
	);

	simd_regfile u_reg (
		.i_clk(i_clk),
		.i_we(reg_we),
		.i_waddr(reg_waddr),
		.i_wdata(o_dramwd),
		.i_re(reg_re),
		.i_raddr(reg_raddr),
		.o_rdata(reg_rdata)
	);

	simd_tmp_buffer u_tbuf (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_push(tbuf_push),
		.i_wdata(o_dramwd),
		.o_rdatas(tbuf_rdatas)
	);

endmodule

// ==== verif/tb_simd_core.sv ====
// simd slice testbench
module tb_simd_core
	import simd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// ==================================================
	// table size and run limit
	// ==================================================
	localparam int N_ENT = 24;
	// per entry operand wait, mul latency, retire stall and handshake slack
	localparam int TIMEOUT_CYC = N_ENT * (5 + 3 + 3 + 2) * 2;

	logic i_clk;
	logic i_rst_n;
	logic i_inst_rdy;
	logic [ISA_BW-1:0] i_inst;
	logic o_inst_ack;
	logic i_sramrd_rdy;
	logic [FLAT_BW-1:0] i_sramrd;
	logic o_sramrd_ack;
	logic o_dramwd_rdy;
	logic [FLAT_BW-1:0] o_dramwd;
	logic i_dramwd_ack;
	logic o_commit_dval;

	// instruction table with one row per entry
	op_e op_t [N_ENT];
	dst_e dst_t [N_ENT];
	logic [REG_ABW-1:0] wa_t [N_ENT];
	logic [REG_ABW-1:0] ra_t [N_ENT];
	srcb_e sb_t [N_ENT];
	logic [IMM_BW-1:0] imm_t [N_ENT];
	logic [ISA_BW-1:0] inst_tbl [N_ENT];
	logic [FLAT_BW-1:0] sram_tbl [N_ENT];
	logic [FLAT_BW-1:0] exp_tbl [N_ENT];

	int err_cnt = 0;
	int chk_cnt = 0;
	int commit_cnt = 0;
	int ack_cnt = 0;
	// entries taken by the DUT as seen by the sram side
	int acc_cnt = 0;
	int cycle_cnt = 0;
	logic busy = 1'b0;

	simd_core DUT (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_inst_rdy(i_inst_rdy),
		.i_inst(i_inst),
		.o_inst_ack(o_inst_ack),
		.i_sramrd_rdy(i_sramrd_rdy),
		.i_sramrd(i_sramrd),
		.o_sramrd_ack(o_sramrd_ack),
		.o_dramwd_rdy(o_dramwd_rdy),
		.o_dramwd(o_dramwd),
		.i_dramwd_ack(i_dramwd_ack),
		.o_commit_dval(o_commit_dval)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	task automatic check_value(input logic [FLAT_BW-1:0] got, input logic [FLAT_BW-1:0] exp,
		input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ==================================================
	// stimulus table and lane model
	// ==================================================
	task automatic set_entry(input int k, input op_e op, input dst_e dst, input int wa,
		input int ra, input srcb_e sb, input logic [IMM_BW-1:0] imm);
		op_t[k] = op;
		dst_t[k] = dst;
		wa_t[k] = REG_ABW'(wa);
		ra_t[k] = REG_ABW'(ra);
		sb_t[k] = sb;
		imm_t[k] = imm;
		inst_tbl[k] = '0;
		inst_tbl[k][OPC_POS +: OPC_BW] = op;
		inst_tbl[k][DST_POS +: DST_BW] = dst;
		inst_tbl[k][WADDR_POS +: WADDR_BW] = REG_ABW'(wa);
		inst_tbl[k][RADDR_POS +: RADDR_BW] = REG_ABW'(ra);
		inst_tbl[k][SRCB_POS +: SRCB_BW] = sb;
		inst_tbl[k][IMM_POS +: IMM_BW] = imm;
		sram_tbl[k] = {$urandom, $urandom};
	endtask

	task automatic build_table();
		// r0..r3 loaded from sram and then echoed to dram
		set_entry(0, OP_MOVB, DST_REG, 0, 0, SRC_SRAM, 8'h00);
		set_entry(1, OP_MOVB, DST_REG, 1, 0, SRC_SRAM, 8'h00);
		set_entry(2, OP_MOVB, DST_REG, 2, 0, SRC_SRAM, 8'h00);
		set_entry(3, OP_MOVB, DST_REG, 3, 0, SRC_SRAM, 8'h00);
		set_entry(4, OP_ADD, DST_DRAM, 0, 0, SRC_IMM, 8'h00);
		set_entry(5, OP_ADD, DST_DRAM, 0, 1, SRC_IMM, 8'h00);
		// arithmetic against immediates of both signs
		set_entry(6, OP_ADD, DST_DRAM, 0, 0, SRC_IMM, 8'h35);
		set_entry(7, OP_SUB, DST_DRAM, 0, 1, SRC_IMM, 8'hf0);
		set_entry(8, OP_MAX, DST_DRAM, 0, 2, SRC_IMM, 8'h80);
		set_entry(9, OP_MUL, DST_DRAM, 0, 0, SRC_IMM, 8'h7b);
		set_entry(10, OP_MUL, DST_DRAM, 0, 3, SRC_IMM, 8'hc3);
		// shifts of the negative vector
		set_entry(11, OP_SHR, DST_DRAM, 0, 3, SRC_IMM, 8'h00);
		set_entry(12, OP_SHR, DST_DRAM, 0, 3, SRC_IMM, 8'h05);
		set_entry(13, OP_SHR, DST_DRAM, 0, 3, SRC_IMM, 8'h0f);
		// five pushes so the first one ages out
		set_entry(14, OP_ADD, DST_TMP, 0, 0, SRC_IMM, 8'h01);
		set_entry(15, OP_SUB, DST_TMP, 0, 1, SRC_IMM, 8'h02);
		set_entry(16, OP_MUL, DST_TMP, 0, 2, SRC_IMM, 8'h03);
		set_entry(17, OP_MAX, DST_TMP, 0, 3, SRC_IMM, 8'h00);
		set_entry(18, OP_ADD, DST_TMP, 0, 0, SRC_SRAM, 8'h00);
		// read back newest first
		set_entry(19, OP_MOVB, DST_DRAM, 0, 0, SRC_TMP, 8'h00);
		set_entry(20, OP_MOVB, DST_DRAM, 0, 0, SRC_TMP, 8'h01);
		set_entry(21, OP_MOVB, DST_DRAM, 0, 0, SRC_TMP, 8'h02);
		set_entry(22, OP_MOVB, DST_DRAM, 0, 0, SRC_TMP, 8'h03);
		set_entry(23, OP_MUL, DST_DRAM, 0, 1, SRC_SRAM, 8'h00);
		// sign bit set in every lane of r3
		sram_tbl[3] = sram_tbl[3] | {VSIZE{16'h8000}};
	endtask

	function automatic logic [DATA_BW-1:0] lane_result(input op_e op, input logic [DATA_BW-1:0] a,
		input logic [DATA_BW-1:0] b, input logic [IMM_BW-1:0] imm);
		logic [2*DATA_BW-1:0] prod;
		prod = (2*DATA_BW)'(a) * (2*DATA_BW)'(b);
		case (op)
			OP_ADD:  lane_result = a + b;
			OP_SUB:  lane_result = a - b;
			OP_MUL:  lane_result = prod[DATA_BW-1:0];
			// logical shift with the vacated top bits filled from the sign
			OP_SHR:  lane_result = (a >> imm[3:0]) |
				(a[DATA_BW-1] ? ~({DATA_BW{1'b1}} >> imm[3:0]) : '0);
			OP_MAX:  lane_result = ($signed(a) > $signed(b)) ? a : b;
			OP_MOVB: lane_result = b;
			default: lane_result = '0;
		endcase
	endfunction

	// walks the table in order with its own register and tmp state
	task automatic build_expected();
		logic [FLAT_BW-1:0] reg_m [NREG];
		logic [FLAT_BW-1:0] tmp_m [TBUF_SIZE];
		logic [FLAT_BW-1:0] a_v;
		logic [FLAT_BW-1:0] b_v;
		logic [FLAT_BW-1:0] r_v;
		logic [DATA_BW-1:0] imm_x;
		for (int i = 0; i < NREG; i++) begin
			reg_m[i] = '0;
		end
		for (int i = 0; i < TBUF_SIZE; i++) begin
			tmp_m[i] = '0;
		end
		for (int k = 0; k < N_ENT; k++) begin
			a_v = reg_m[ra_t[k]];
			imm_x = {{(DATA_BW-IMM_BW){imm_t[k][IMM_BW-1]}}, imm_t[k]};
			case (sb_t[k])
				SRC_TMP:  b_v = tmp_m[imm_t[k][1:0]];
				SRC_IMM:  b_v = {VSIZE{imm_x}};
				SRC_SRAM: b_v = sram_tbl[k];
				default:  b_v = '0;
			endcase
			for (int l = 0; l < VSIZE; l++) begin
				r_v[l*DATA_BW +: DATA_BW] = lane_result(op_t[k], a_v[l*DATA_BW +: DATA_BW],
					b_v[l*DATA_BW +: DATA_BW], imm_t[k]);
			end
			exp_tbl[k] = r_v;
			if (dst_t[k] == DST_REG) begin
				reg_m[wa_t[k]] = r_v;
			end else if (dst_t[k] == DST_TMP) begin
				for (int i = TBUF_SIZE-1; i > 0; i--) begin
					tmp_m[i] = tmp_m[i-1];
				end
				tmp_m[0] = r_v;
			end
		end
	endtask

	// ==================================================
	// port drivers
	// ==================================================
	task automatic drive_instructions();
		logic got;
		@(negedge i_clk);
		for (int k = 0; k < N_ENT; k++) begin
			i_inst_rdy = 1'b1;
			i_inst = inst_tbl[k];
			got = 1'b0;
			// ack sampled mid low phase with the transfer at the next rising edge
			while (!got) begin
				#1;
				got = o_inst_ack;
				@(negedge i_clk);
			end
			acc_cnt++;
		end
		i_inst_rdy = 1'b0;
		i_inst = '0;
	endtask

	task automatic serve_sram();
		int stall;
		logic got;
		for (int k = 0; k < N_ENT; k++) begin
			if (sb_t[k] == SRC_SRAM) begin
				wait (acc_cnt > k);
				@(negedge i_clk);
				stall = $urandom_range(3, 0);
				repeat (stall) @(negedge i_clk);
				i_sramrd_rdy = 1'b1;
				i_sramrd = sram_tbl[k];
				got = 1'b0;
				while (!got) begin
					#1;
					got = o_sramrd_ack;
					@(negedge i_clk);
				end
				i_sramrd_rdy = 1'b0;
				i_sramrd = '0;
			end
		end
	endtask

	task automatic serve_dram();
		int stall;
		logic [FLAT_BW-1:0] held;
		for (int k = 0; k < N_ENT; k++) begin
			if (dst_t[k] == DST_DRAM) begin
				do begin
					@(negedge i_clk);
					#1;
				end while (!o_dramwd_rdy);
				held = o_dramwd;
				stall = $urandom_range(3, 0);
				// result must sit still until acked
				repeat (stall) begin
					@(negedge i_clk);
					#1;
					check_value(FLAT_BW'(o_dramwd_rdy), FLAT_BW'(1), "dram rdy dropped before ack");
					check_value(o_dramwd, held, "dram data changed while waiting for ack");
				end
				@(negedge i_clk);
				i_dramwd_ack = 1'b1;
				#1;
				check_value(o_dramwd, exp_tbl[k], $sformatf("dram result of entry %0d", k));
				@(negedge i_clk);
				i_dramwd_ack = 1'b0;
			end
		end
	endtask

	// ==================================================
	// monitors and run control
	// ==================================================
	// one ack per commit and nothing accepted while busy
	always begin
		@(negedge i_clk);
		#1;
		if (i_rst_n) begin
			if (o_inst_ack) begin
				check_value(FLAT_BW'(busy), '0, "instruction acked before previous commit");
				busy = 1'b1;
				ack_cnt++;
			end
			if (o_commit_dval) begin
				busy = 1'b0;
				commit_cnt++;
			end
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("run timed out after %0d cycles, %0d of %0d committed",
			cycle_cnt, commit_cnt, N_ENT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'hfc09));
		i_rst_n = 1'b0;
		i_inst_rdy = 1'b0;
		i_inst = '0;
		i_sramrd_rdy = 1'b0;
		i_sramrd = '0;
		i_dramwd_ack = 1'b0;
		build_table();
		build_expected();
		// two rising edges in reset, released on the falling edge after them
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		#1;
		// handshake outputs idle out of reset
		check_value(FLAT_BW'(o_inst_ack), '0, "inst ack high after reset");
		check_value(FLAT_BW'(o_sramrd_ack), '0, "sram ack high after reset");
		check_value(FLAT_BW'(o_dramwd_rdy), '0, "dram rdy high after reset");
		check_value(FLAT_BW'(o_commit_dval), '0, "commit high after reset");
		fork
			drive_instructions();
			serve_sram();
			serve_dram();
		join
		while (commit_cnt < N_ENT) @(negedge i_clk);
		// a few idle cycles to catch stray commits
		repeat (4) @(negedge i_clk);
		check_value(FLAT_BW'(commit_cnt), FLAT_BW'(N_ENT), "commit count");
		check_value(FLAT_BW'(ack_cnt), FLAT_BW'(N_ENT), "instruction ack count");
		$display("checks %0d, errors %0d, commits %0d of %0d",
			chk_cnt, err_cnt, commit_cnt, N_ENT);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/simd_pkg.sv
source/simd_sequencer.sv
source/simd_op_timer.sv
source/simd_alu.sv
source/simd_regfile.sv
source/simd_tmp_buffer.sv
source/simd_core.sv
verif/tb_simd_core.sv

// ==== Makefile ====
# Verilator build and run of the simd slice testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_simd_core
RTL_TOP   := simd_core
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(wildcard source/*.sv verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
